// ==== vlog.f ====
+incdir+src
src/csr_reg_pkg.sv
src/csr_port_pkg.sv
src/csr_write_stage.sv
src/csr_mode_regs.sv
src/csr_timer.sv
src/csr_save_read.sv
src/csr_file.sv
verification/csr_file_asserts.sv
verification/csr_file_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= csr_file_tb
RTL_TOP   ?= csr_file
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/csr_file_tb.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_file_tb;

    localparam int MAX_HOLD    = 6;
    localparam int WEN_WAIT    = 4;
    localparam int INITVAL     = 5;
    localparam int WRITE_LEN   = MAX_HOLD + WEN_WAIT + 4;
    localparam int RESET_LEN   = 16;
    localparam int STAGED_LEN  = 5 * WRITE_LEN + 4;
    localparam int EENTRY_LEN  = WRITE_LEN;
    localparam int CRMD_LEN    = 4 * WRITE_LEN;
    localparam int EXC_LEN     = 2 * WRITE_LEN + 8;
    localparam int IRQ_LEN     = 3 * WRITE_LEN + 4;
    localparam int TIMER_WAIT  = 4 * INITVAL + 10;
    localparam int QUIET_LEN   = 8 * INITVAL;
    localparam int TIMER_LEN   = 3 * WRITE_LEN + QUIET_LEN;
    localparam int CYCLE_LIMIT = 2 * (RESET_LEN + STAGED_LEN + EENTRY_LEN + CRMD_LEN + EXC_LEN
                                      + IRQ_LEN + TIMER_LEN) + TIMER_WAIT;

    logic                      clk;
    logic                      aresetn;
    logic                      wen_in;
    csr_port_pkg::csr_write_t  wr_req;
    csr_reg_pkg::csr_addr_t    addr_in;
    logic                      d_idle;
    logic                      exception;
    logic                      ertn;
    csr_port_pkg::exc_report_t exc;
    csr_reg_pkg::hw_irq_t      hardware_interrupt;
    csr_reg_pkg::csr_data_t    rdata;
    csr_reg_pkg::csr_data_t    crmd;
    csr_reg_pkg::csr_data_t    estat;
    csr_reg_pkg::csr_data_t    era_out;
    csr_reg_pkg::csr_data_t    eentry;
    logic                      cpu_interrupt;
    logic                      idle_over;
    logic                      wen_csr;

    int value_errors;
    int other_errors;
    int cycles;

    csr_file u_csr_file (
        .clk                (clk),
        .aresetn            (aresetn),
        .wen_in             (wen_in),
        .wr_req             (wr_req),
        .addr_in            (addr_in),
        .d_idle             (d_idle),
        .exception          (exception),
        .ertn               (ertn),
        .exc                (exc),
        .hardware_interrupt (hardware_interrupt),
        .rdata              (rdata),
        .crmd               (crmd),
        .estat              (estat),
        .era_out            (era_out),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over),
        .wen_csr            (wen_csr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("checks done: %0d value errors, %0d other errors",
                     value_errors, other_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_data(input string name, input csr_reg_pkg::csr_data_t exp,
                              input csr_reg_pkg::csr_data_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    // CRMD word with DATF and DATM kept at 1
    function automatic csr_reg_pkg::csr_data_t build_crmd(input csr_reg_pkg::plv_t plv,
                                                          input logic ie, input logic pg,
                                                          input logic da);
        csr_reg_pkg::csr_data_t v;
        v              = '0;
        v[`CRMD_PLV]   = plv;
        v[`CRMD_IE]    = ie;
        v[`CRMD_PG]    = pg;
        v[`CRMD_DA]    = da;
        v[`CRMD_DATF]  = 2'd1;
        v[`CRMD_DATM]  = 2'd1;
        return v;
    endfunction

    task automatic read_csr(input csr_reg_pkg::csr_addr_t addr,
                            output csr_reg_pkg::csr_data_t data);
        @(posedge clk);
        addr_in <= addr;
        @(negedge clk);
        data = rdata;
    endtask

    // Called just after a rising edge with a request pending
    task automatic await_commit(input csr_reg_pkg::csr_addr_t addr);
        int n;
        d_idle <= 1'b1;
        @(negedge clk);
        n = 0;
        while (!wen_csr && n < WEN_WAIT) begin
            n++;
            @(negedge clk);
        end
        if (!wen_csr) begin
            other_errors++;
            $display("write to %h: wen_csr did not rise while d_idle was high", addr);
        end
        @(posedge clk);
        d_idle <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic staged_write(input csr_reg_pkg::csr_addr_t addr,
                                input csr_reg_pkg::csr_data_t data, input int hold,
                                input csr_reg_pkg::csr_data_t old_val, input bit check_old);
        @(posedge clk);
        wen_in      <= 1'b1;
        wr_req.addr <= addr;
        wr_req.data <= data;
        addr_in     <= addr;
        d_idle      <= 1'b0;
        @(posedge clk);
        wen_in <= 1'b0;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_flag("staged hold wen_csr", 1'b0, wen_csr);
            if (check_old) begin
                check_data("staged hold value", old_val, rdata);
            end
            @(posedge clk);
        end
        await_commit(addr);
    endtask

    task automatic test_reset_values();
        csr_reg_pkg::csr_data_t v;
        check_flag("reset wen_csr", 1'b0, wen_csr);
        check_flag("reset cpu_interrupt", 1'b0, cpu_interrupt);
        check_flag("reset idle_over", 1'b0, idle_over);
        check_data("reset eentry", '0, eentry);
        read_csr(`CSR_CRMD, v);
        check_data("reset crmd", build_crmd(2'd0, 1'b0, 1'b0, 1'b1), v);
        read_csr(`CSR_ESTAT, v);
        check_data("reset estat", '0, v);
        read_csr(`CSR_SAVE0, v);
        check_data("reset save0", '0, v);
    endtask

    task automatic test_staged_write();
        csr_reg_pkg::csr_data_t save_model [4];
        csr_reg_pkg::csr_data_t data;
        csr_reg_pkg::csr_data_t first;
        csr_reg_pkg::csr_data_t v;
        int hold;
        for (int i = 0; i < 4; i++) begin
            save_model[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            data = $urandom;
            hold = $urandom_range(1, MAX_HOLD);
            staged_write(csr_reg_pkg::csr_addr_t'(`CSR_SAVE0 + i), data, hold,
                         save_model[i], 1'b1);
            check_data("staged save value", data, rdata);
            save_model[i] = data;
        end
        // Second request before idle replaces the first
        first = $urandom;
        data  = $urandom;
        @(posedge clk);
        wen_in      <= 1'b1;
        wr_req.addr <= `CSR_SAVE0;
        wr_req.data <= first;
        d_idle      <= 1'b0;
        @(posedge clk);
        wr_req.addr <= `CSR_SAVE1;
        wr_req.data <= data;
        @(posedge clk);
        wen_in <= 1'b0;
        await_commit(`CSR_SAVE1);
        read_csr(`CSR_SAVE0, v);
        check_data("replaced save0", save_model[0], v);
        read_csr(`CSR_SAVE1, v);
        check_data("replacing save1", data, v);
    endtask

    // Only the VA field of EENTRY holds bits
    task automatic test_eentry();
        csr_reg_pkg::csr_data_t data;
        csr_reg_pkg::csr_data_t exp;
        data            = $urandom;
        exp             = '0;
        exp[`EENTRY_VA] = data[`EENTRY_VA];
        staged_write(`CSR_EENTRY, data, 1, '0, 1'b1);
        check_data("eentry port", exp, eentry);
        check_data("eentry read", exp, rdata);
    endtask

    task automatic test_crmd_rule();
        logic [1:0]        pairs [4];
        csr_reg_pkg::plv_t plv;
        logic              ie;
        logic              pg;
        logic              da;
        logic              exp_pg;
        logic              exp_da;
        pairs  = '{2'b01, 2'b10, 2'b11, 2'b00};
        exp_pg = 1'b0;
        exp_da = 1'b1;
        for (int i = 0; i < 4; i++) begin
            plv      = csr_reg_pkg::plv_t'($urandom_range(0, 3));
            ie       = ($urandom_range(0, 1) != 0);
            {pg, da} = pairs[i];
            if (pg != da) begin
                exp_pg = pg;
                exp_da = da;
            end
            staged_write(`CSR_CRMD, build_crmd(plv, ie, pg, da), 0, '0, 1'b0);
            check_data("crmd rule port", build_crmd(plv, ie, exp_pg, exp_da), crmd);
            check_data("crmd rule read", build_crmd(plv, ie, exp_pg, exp_da), rdata);
        end
    endtask

    task automatic test_exception();
        csr_reg_pkg::ecode_t    code;
        csr_reg_pkg::csr_data_t era_val;
        csr_reg_pkg::csr_data_t badv_val;
        csr_reg_pkg::csr_data_t exp;
        csr_reg_pkg::csr_data_t v;
        code     = csr_reg_pkg::ecode_t'($urandom_range(1, 63));
        era_val  = $urandom;
        badv_val = $urandom;
        staged_write(`CSR_CRMD, build_crmd(2'd3, 1'b1, 1'b0, 1'b1), 0, '0, 1'b0);
        @(posedge clk);
        exception      <= 1'b1;
        exc.code_valid <= 1'b1;
        exc.code_sub   <= 1'b1;
        exc.code       <= code;
        exc.era_valid  <= 1'b1;
        exc.era        <= era_val;
        exc.badv_valid <= 1'b1;
        exc.badv       <= badv_val;
        @(posedge clk);
        exception <= 1'b0;
        exc       <= '0;
        @(negedge clk);
        check_data("exception crmd", build_crmd(2'd0, 1'b0, 1'b0, 1'b1), crmd);
        check_data("exception era", era_val, era_out);
        exp                  = '0;
        exp[`ESTAT_ECODE]    = code;
        exp[`ESTAT_ESUBCODE] = 9'd1;
        check_data("exception estat", exp, estat);
        exp              = '0;
        exp[`PRMD_PPLV]  = 2'd3;
        exp[`PRMD_PIE]   = 1'b1;
        read_csr(`CSR_PRMD, v);
        check_data("exception prmd", exp, v);
        read_csr(`CSR_BADV, v);
        check_data("exception badv", badv_val, v);
        @(posedge clk);
        ertn <= 1'b1;
        @(posedge clk);
        ertn <= 1'b0;
        @(negedge clk);
        check_data("ertn crmd", build_crmd(2'd3, 1'b1, 1'b0, 1'b1), crmd);
    endtask

    task automatic test_irq_masking();
        csr_reg_pkg::hw_irq_t   lines;
        csr_reg_pkg::csr_data_t lie;
        int                     line;
        line        = $urandom_range(0, 7);
        lines       = '0;
        lines[line] = 1'b1;
        lie         = '0;
        lie[line + 2] = 1'b1;
        staged_write(`CSR_CRMD, build_crmd(2'd0, 1'b0, 1'b0, 1'b1), 0, '0, 1'b0);
        @(posedge clk);
        hardware_interrupt <= lines;
        @(negedge clk);
        check_flag("irq idle_over", 1'b1, idle_over);
        check_flag("irq not enabled", 1'b0, cpu_interrupt);
        staged_write(`CSR_ECFG, lie, 0, '0, 1'b0);
        check_data("irq ecfg", lie, rdata);
        check_flag("irq ie clear", 1'b0, cpu_interrupt);
        staged_write(`CSR_CRMD, build_crmd(2'd0, 1'b1, 1'b0, 1'b1), 0, '0, 1'b0);
        check_flag("irq enabled", 1'b1, cpu_interrupt);
        @(posedge clk);
        hardware_interrupt <= '0;
        @(negedge clk);
        check_flag("irq dropped idle_over", 1'b0, idle_over);
        check_flag("irq dropped cpu_interrupt", 1'b0, cpu_interrupt);
    endtask

    task automatic test_timer();
        csr_reg_pkg::csr_data_t lie;
        csr_reg_pkg::csr_data_t tcfg_word;
        csr_reg_pkg::csr_data_t clr_word;
        int                     n;
        lie                     = '0;
        lie[`CSR_TI_BIT]        = 1'b1;
        tcfg_word               = '0;
        tcfg_word[`TCFG_INITVAL] = csr_reg_pkg::initval_t'(INITVAL);
        tcfg_word[`TCFG_EN]     = 1'b1;
        clr_word                = '0;
        clr_word[`TICLR_CLR]    = 1'b1;
        staged_write(`CSR_ECFG, lie, 0, '0, 1'b0);
        staged_write(`CSR_TCFG, tcfg_word, 0, '0, 1'b0);
        check_data("timer tcfg", tcfg_word, rdata);
        n = 0;
        while (!estat[`CSR_TI_BIT] && n < TIMER_WAIT) begin
            n++;
            @(negedge clk);
        end
        if (!estat[`CSR_TI_BIT]) begin
            other_errors++;
            $display("timer interrupt did not set within %0d cycles", TIMER_WAIT);
        end
        check_flag("timer cpu_interrupt", 1'b1, cpu_interrupt);
        staged_write(`CSR_TICLR, clr_word, 0, '0, 1'b0);
        check_data("timer ticlr read", '0, rdata);
        check_flag("timer cleared", 1'b0, estat[`CSR_TI_BIT]);
        // One-shot, so no second timeout
        repeat (QUIET_LEN) begin
            @(negedge clk);
            check_flag("timer stays clear", 1'b0, estat[`CSR_TI_BIT]);
        end
    endtask

    initial begin
        void'($urandom(93));
        value_errors       = 0;
        other_errors       = 0;
        cycles             = 0;
        clk                = 1'b0;
        aresetn            = 1'b0;
        wen_in             = 1'b0;
        wr_req             = '0;
        addr_in            = '0;
        d_idle             = 1'b0;
        exception          = 1'b0;
        ertn               = 1'b0;
        exc                = '0;
        hardware_interrupt = '0;
        repeat (10) @(posedge clk);
        aresetn <= 1'b1;
        @(negedge clk);
        test_reset_values();
        test_staged_write();
        test_eentry();
        test_crmd_rule();
        test_exception();
        test_irq_masking();
        test_timer();
        $display("checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/csr_file_asserts.sv ====
`timescale 1ns/1ps

module csr_file_asserts (
    input logic clk,
    input logic aresetn,
    input logic wen_csr,
    input logic commit,
    input logic d_idle,
    input logic cpu_interrupt
);

    // Commit lands exactly one cycle after wen_csr
    assert property (@(posedge clk) disable iff (!aresetn) wen_csr |=> commit)
        else $error("commit did not follow wen_csr");

    assert property (@(posedge clk) disable iff (!aresetn) commit |-> $past(wen_csr))
        else $error("commit without wen_csr in the previous cycle");

    assert property (@(posedge clk) disable iff (!aresetn) commit |=> !commit)
        else $error("commit high for two cycles in a row");

    assert property (@(posedge clk) disable iff (!aresetn) wen_csr |-> d_idle)
        else $error("wen_csr high while d_idle is low");

    assert property (@(posedge clk) disable iff (!aresetn) !$isunknown(cpu_interrupt))
        else $error("cpu_interrupt is unknown");

endmodule

bind csr_file csr_file_asserts u_asserts (
    .clk           (clk),
    .aresetn       (aresetn),
    .wen_csr       (wen_csr),
    .commit        (commit),
    .d_idle        (d_idle),
    .cpu_interrupt (cpu_interrupt)
);

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      wen_in,
    input  csr_port_pkg::csr_write_t  wr_req,
    input  csr_reg_pkg::csr_addr_t    addr_in,
    input  logic                      d_idle,
    input  logic                      exception,
    input  logic                      ertn,
    input  csr_port_pkg::exc_report_t exc,
    input  csr_reg_pkg::hw_irq_t      hardware_interrupt,
    output csr_reg_pkg::csr_data_t    rdata,
    output csr_reg_pkg::csr_data_t    crmd,
    output csr_reg_pkg::csr_data_t    estat,
    output csr_reg_pkg::csr_data_t    era_out,
    output csr_reg_pkg::csr_data_t    eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over,
    output logic                      wen_csr
);

    logic                     commit;
    csr_port_pkg::csr_write_t commit_req;
    csr_reg_pkg::csr_data_t   prmd;
    csr_reg_pkg::csr_data_t   ecfg;
    csr_reg_pkg::csr_data_t   badv;
    csr_reg_pkg::csr_data_t   tcfg;
    csr_reg_pkg::csr_data_t   tval;
    logic                     timer_irq;

    csr_write_stage u_write_stage (
        .clk        (clk),
        .aresetn    (aresetn),
        .wen_in     (wen_in),
        .wr_req     (wr_req),
        .d_idle     (d_idle),
        .wen_csr    (wen_csr),
        .commit     (commit),
        .commit_req (commit_req)
    );

    csr_mode_regs u_mode_regs (
        .clk                (clk),
        .aresetn            (aresetn),
        .commit             (commit),
        .commit_req         (commit_req),
        .exception          (exception),
        .ertn               (ertn),
        .exc                (exc),
        .hardware_interrupt (hardware_interrupt),
        .timer_irq          (timer_irq),
        .crmd               (crmd),
        .prmd               (prmd),
        .ecfg               (ecfg),
        .estat              (estat),
        .era                (era_out),
        .badv               (badv),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over)
    );

    csr_timer u_timer (
        .clk        (clk),
        .aresetn    (aresetn),
        .commit     (commit),
        .commit_req (commit_req),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_irq  (timer_irq)
    );

    csr_save_read u_save_read (
        .clk        (clk),
        .aresetn    (aresetn),
        .commit     (commit),
        .commit_req (commit_req),
        .addr_in    (addr_in),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .estat      (estat),
        .era        (era_out),
        .badv       (badv),
        .eentry     (eentry),
        .tcfg       (tcfg),
        .tval       (tval),
        .rdata      (rdata)
    );

endmodule

// ==== src/csr_save_read.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_save_read (
    input  logic                     clk,
    input  logic                     aresetn,
    input  logic                     commit,
    input  csr_port_pkg::csr_write_t commit_req,
    input  csr_reg_pkg::csr_addr_t   addr_in,
    input  csr_reg_pkg::csr_data_t   crmd,
    input  csr_reg_pkg::csr_data_t   prmd,
    input  csr_reg_pkg::csr_data_t   ecfg,
    input  csr_reg_pkg::csr_data_t   estat,
    input  csr_reg_pkg::csr_data_t   era,
    input  csr_reg_pkg::csr_data_t   badv,
    input  csr_reg_pkg::csr_data_t   eentry,
    input  csr_reg_pkg::csr_data_t   tcfg,
    input  csr_reg_pkg::csr_data_t   tval,
    output csr_reg_pkg::csr_data_t   rdata
);

    csr_reg_pkg::csr_data_t save_q [4];
    logic [3:0]             save_we;

    assign save_we[0] = commit && commit_req.addr == `CSR_SAVE0;
    assign save_we[1] = commit && commit_req.addr == `CSR_SAVE1;
    assign save_we[2] = commit && commit_req.addr == `CSR_SAVE2;
    assign save_we[3] = commit && commit_req.addr == `CSR_SAVE3;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!aresetn) begin
                save_q[i] <= '0;
            end else if (save_we[i]) begin
                save_q[i] <= commit_req.data;
            end
        end
    end

    always_comb begin
        case (addr_in)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save_q[0];
            `CSR_SAVE1:  rdata = save_q[1];
            `CSR_SAVE2:  rdata = save_q[2];
            `CSR_SAVE3:  rdata = save_q[3];
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = tval;
            // Write-only clear register
            `CSR_TICLR:  rdata = '0;
            default:     rdata = '0;
        endcase
    end

endmodule

// ==== src/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_timer (
    input  logic                     clk,
    input  logic                     aresetn,
    input  logic                     commit,
    input  csr_port_pkg::csr_write_t commit_req,
    output csr_reg_pkg::csr_data_t   tcfg,
    output csr_reg_pkg::csr_data_t   tval,
    output logic                     timer_irq
);

    logic                   tcfg_en;
    logic                   tcfg_periodic;
    csr_reg_pkg::initval_t  tcfg_initval;
    csr_reg_pkg::tval_t     tval_q;
    logic                   load_q;
    logic                   timeout;
    logic                   ti_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            {tcfg_initval, tcfg_periodic, tcfg_en} <= `CSR_TCFG_RESET;
        end else if (commit && commit_req.addr == `CSR_TCFG) begin
            tcfg_en       <= commit_req.data[`TCFG_EN];
            tcfg_periodic <= commit_req.data[`TCFG_PERIODIC];
            tcfg_initval  <= commit_req.data[`TCFG_INITVAL];
        end
    end

    // Restart one cycle after the new TCFG is in place
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            load_q <= 1'b0;
        end else begin
            load_q <= commit && commit_req.addr == `CSR_TCFG;
        end
    end

    // Initial value carries 01 below it, so initval 0 still fires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_q <= `CSR_TVAL_RESET;
        end else if (load_q) begin
            tval_q <= {tcfg_initval, 2'b01};
        end else if (tval_q == '0) begin
            if (tcfg_periodic) tval_q <= {tcfg_initval, 2'b01};
        end else if (tcfg_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    assign timeout = tcfg_en && !load_q && (tval_q == 32'd1);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti_q <= 1'b0;
        end else if (commit && commit_req.addr == `CSR_TICLR && commit_req.data[`TICLR_CLR]) begin
            ti_q <= 1'b0;
        end else if (timeout) begin
            ti_q <= 1'b1;
        end
    end

    assign tcfg      = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval      = tval_q;
    assign timer_irq = ti_q;

endmodule

// ==== src/csr_mode_regs.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_mode_regs (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      commit,
    input  csr_port_pkg::csr_write_t  commit_req,
    input  logic                      exception,
    input  logic                      ertn,
    input  csr_port_pkg::exc_report_t exc,
    input  csr_reg_pkg::hw_irq_t      hardware_interrupt,
    input  logic                      timer_irq,
    output csr_reg_pkg::csr_data_t    crmd,
    output csr_reg_pkg::csr_data_t    prmd,
    output csr_reg_pkg::csr_data_t    ecfg,
    output csr_reg_pkg::csr_data_t    estat,
    output csr_reg_pkg::csr_data_t    era,
    output csr_reg_pkg::csr_data_t    badv,
    output csr_reg_pkg::csr_data_t    eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over
);

    csr_reg_pkg::plv_t      crmd_plv;
    logic                   crmd_ie;
    logic                   crmd_da;
    logic                   crmd_pg;
    logic [1:0]             crmd_datf;
    logic [1:0]             crmd_datm;
    csr_reg_pkg::plv_t      prmd_pplv;
    logic                   prmd_pie;
    csr_reg_pkg::irq_vec_t  ecfg_lie;
    logic [1:0]             estat_is_soft;
    csr_reg_pkg::ecode_t    estat_ecode;
    csr_reg_pkg::esubcode_t estat_esubcode;
    csr_reg_pkg::csr_data_t era_q;
    csr_reg_pkg::csr_data_t badv_q;
    logic [25:0]            eentry_va;
    csr_reg_pkg::irq_vec_t  estat_is;
    csr_reg_pkg::csr_data_t wdata;
    logic                   pg_new;
    logic                   da_new;

    assign wdata  = commit_req.data;
    assign pg_new = wdata[`CRMD_PG];
    assign da_new = wdata[`CRMD_DA];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'd1;
            crmd_datm <= 2'd1;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (exception) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (commit && commit_req.addr == `CSR_CRMD) begin
            crmd_plv  <= wdata[`CRMD_PLV];
            crmd_ie   <= wdata[`CRMD_IE];
            crmd_datf <= wdata[`CRMD_DATF];
            crmd_datm <= wdata[`CRMD_DATM];
            // PG and DA must stay one-hot
            if (pg_new ^ da_new) begin
                crmd_pg <= pg_new;
                crmd_da <= da_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exception) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (commit && commit_req.addr == `CSR_PRMD) begin
            prmd_pplv <= wdata[`PRMD_PPLV];
            prmd_pie  <= wdata[`PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie      <= '0;
            estat_is_soft <= '0;
            eentry_va     <= '0;
        end else if (commit) begin
            if (commit_req.addr == `CSR_ECFG) ecfg_lie <= wdata[`ECFG_LIE];
            if (commit_req.addr == `CSR_ESTAT) estat_is_soft <= wdata[`ESTAT_IS_SOFT];
            if (commit_req.addr == `CSR_EENTRY) eentry_va <= wdata[`EENTRY_VA];
        end
    end

    // Report fields beat a CPU write to the same register
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
            badv_q         <= '0;
        end else begin
            if (exc.code_valid) begin
                estat_ecode    <= exc.code;
                estat_esubcode <= (exc.code == '0) ? '0 : {8'b0, exc.code_sub};
            end
            if (exc.era_valid) begin
                era_q <= exc.era;
            end else if (commit && commit_req.addr == `CSR_ERA) begin
                era_q <= wdata;
            end
            if (exc.badv_valid) begin
                badv_q <= exc.badv;
            end else if (commit && commit_req.addr == `CSR_BADV) begin
                badv_q <= wdata;
            end
        end
    end

    // Pending lines, IPI stays zero
    always_comb begin
        estat_is = '0;
        estat_is[`ESTAT_IS_SOFT] = estat_is_soft;
        estat_is[`ESTAT_IS_HARD] = hardware_interrupt;
        estat_is[`CSR_TI_BIT]    = timer_irq;
    end

    always_comb begin
        crmd = '0;
        crmd[`CRMD_PLV]  = crmd_plv;
        crmd[`CRMD_IE]   = crmd_ie;
        crmd[`CRMD_DA]   = crmd_da;
        crmd[`CRMD_PG]   = crmd_pg;
        crmd[`CRMD_DATF] = crmd_datf;
        crmd[`CRMD_DATM] = crmd_datm;
        prmd = '0;
        prmd[`PRMD_PPLV] = prmd_pplv;
        prmd[`PRMD_PIE]  = prmd_pie;
        ecfg = '0;
        ecfg[`ECFG_LIE]  = ecfg_lie;
        estat = '0;
        estat[`CSR_IRQ_NUM-1:0] = estat_is;
        estat[`ESTAT_ECODE]     = estat_ecode;
        estat[`ESTAT_ESUBCODE]  = estat_esubcode;
        eentry = '0;
        eentry[`EENTRY_VA] = eentry_va;
    end

    assign era           = era_q;
    assign badv          = badv_q;
    assign cpu_interrupt = crmd_ie && |(ecfg_lie & estat_is);
    // Any pending line ends idle, enabled or not
    assign idle_over     = |estat_is;

endmodule

// ==== src/csr_write_stage.sv ====
`timescale 1ns/1ps

module csr_write_stage (
    input  logic                    clk,
    input  logic                    aresetn,
    input  logic                    wen_in,
    input  csr_port_pkg::csr_write_t wr_req,
    input  logic                    d_idle,
    output logic                    wen_csr,
    output logic                    commit,
    output csr_port_pkg::csr_write_t commit_req
);

    csr_port_pkg::wr_state_e state;
    csr_port_pkg::wr_state_e state_next;
    csr_port_pkg::csr_write_t req_q;

    // Latest request wins, also while an older one waits
    always_ff @(posedge clk) begin
        if (wen_in) begin
            req_q <= wr_req;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            csr_port_pkg::WR_IDLE: begin
                if (wen_in) begin
                    state_next = csr_port_pkg::WR_PENDING;
                end
            end
            csr_port_pkg::WR_PENDING: begin
                if (d_idle) begin
                    state_next = csr_port_pkg::WR_COMMIT;
                end
            end
            csr_port_pkg::WR_COMMIT: begin
                // A request arriving now becomes the next pending one
                state_next = wen_in ? csr_port_pkg::WR_PENDING : csr_port_pkg::WR_IDLE;
            end
            default: state_next = csr_port_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= csr_port_pkg::WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign wen_csr    = (state == csr_port_pkg::WR_PENDING) && d_idle;
    assign commit     = (state == csr_port_pkg::WR_COMMIT);
    assign commit_req = req_q;

endmodule

// ==== src/csr_port_pkg.sv ====
package csr_port_pkg;

    // One CSR write from the pipeline
    typedef struct packed {
        csr_reg_pkg::csr_addr_t addr;
        csr_reg_pkg::csr_data_t data;
    } csr_write_t;

    // Exception report, each part with its own valid flag
    typedef struct packed {
        logic                   code_valid;
        logic                   code_sub;
        csr_reg_pkg::ecode_t    code;
        logic                   era_valid;
        csr_reg_pkg::csr_data_t era;
        logic                   badv_valid;
        csr_reg_pkg::csr_data_t badv;
    } exc_report_t;

    // Write staging FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_PENDING,
        WR_COMMIT
    } wr_state_e;

endpackage

// ==== src/csr_reg_pkg.sv ====
`include "csr_defs.svh"

package csr_reg_pkg;

    // Full register value as seen on the read port
    typedef logic [31:0] csr_data_t;

    // CSR number from the instruction
    typedef logic [13:0] csr_addr_t;

    // Privilege level, 0 is kernel and 3 is user
    typedef logic [1:0] plv_t;

    // ESTAT exception code and subcode
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // Interrupt status and local enable bits
    typedef logic [`CSR_IRQ_NUM-1:0] irq_vec_t;

    // External interrupt pins
    typedef logic [`CSR_HW_IRQ_NUM-1:0] hw_irq_t;

    // Timer countdown value
    typedef logic [31:0] tval_t;

    // TCFG initial value, two low bits appended on load
    typedef logic [29:0] initval_t;

endpackage

// ==== src/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// CSR addresses
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// Field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ECFG_LIE        12:0
`define ESTAT_IS_SOFT   1:0
`define ESTAT_IS_HARD   9:2
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22
`define EENTRY_VA       31:6
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

// Timer state after reset
`define CSR_TCFG_RESET  32'h0000_0000
`define CSR_TVAL_RESET  32'h0000_0000

// Interrupt lines
`define CSR_HW_IRQ_NUM  8
`define CSR_IRQ_NUM     13
`define CSR_TI_BIT      11

`endif
